/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_gfx_sched -f project.f
	@out="$$(./obj_dir/Vtb_gfx_sched)"; echo "$$out"; \
		echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

/* design/apb_master.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_master (
	input  wire                     clk,
	input  wire                     rst_n,

	input  wire                     xfer_req,
	input  wire gfx_bus_pkg::addr_t xfer_addr,
	input  wire gfx_bus_pkg::word_t xfer_wdata,
	input  wire gfx_bus_pkg::strb_t xfer_wstrb,
	output logic                    xfer_done,
	output gfx_bus_pkg::word_t      xfer_rdata,

	output logic                    psel,
	output logic                    penable,
	output logic                    pwrite,
	output gfx_bus_pkg::addr_t      paddr,
	output gfx_bus_pkg::word_t      pwdata,
	output gfx_bus_pkg::strb_t      pstrb,
	input  wire                     pready,
	input  wire gfx_bus_pkg::word_t prdata
);

	import gfx_bus_pkg::*;
	import gfx_sched_pkg::*;

	apb_state_e state;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= APB_IDLE;
		end else begin
			case (state)
				APB_IDLE: begin
					if (xfer_req) begin
						state <= APB_SETUP;
					end
				end
				APB_SETUP: begin
					state <= APB_ACCESS;
				end
				APB_ACCESS: begin
					if (pready) begin
						state <= APB_IDLE;
					end
				end
				default: begin
					state <= APB_IDLE;
				end
			endcase
		end
	end

	// fields are frozen at setup and stay put until the slave is ready.
	always_ff @(posedge clk) begin
		if (state == APB_IDLE && xfer_req) begin
			paddr  <= xfer_addr;
			pwdata <= xfer_wdata;
			pstrb  <= xfer_wstrb;
		end
	end

	assign psel       = (state != APB_IDLE);
	assign penable    = (state == APB_ACCESS);
	assign pwrite     = |pstrb;
	assign xfer_done  = penable && pready;
	assign xfer_rdata = prdata;

endmodule

`default_nettype wire

/* design/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input  wire                     clk,
	input  wire                     rst_n,

	input  wire                     req0,
	input  wire                     req1,
	input  wire gfx_bus_pkg::addr_t addr0,
	input  wire gfx_bus_pkg::addr_t addr1,
	input  wire gfx_bus_pkg::word_t wdata0,
	input  wire gfx_bus_pkg::word_t wdata1,
	input  wire gfx_bus_pkg::strb_t wstrb0,
	input  wire gfx_bus_pkg::strb_t wstrb1,
	output logic                    done0,
	output logic                    done1,
	output gfx_bus_pkg::word_t      rdata0,
	output gfx_bus_pkg::word_t      rdata1,

	output logic                    xfer_req,
	output gfx_bus_pkg::addr_t      xfer_addr,
	output gfx_bus_pkg::word_t      xfer_wdata,
	output gfx_bus_pkg::strb_t      xfer_wstrb,
	input  wire                     xfer_done,
	input  wire gfx_bus_pkg::word_t xfer_rdata
);

	import gfx_bus_pkg::*;
	import gfx_sched_pkg::*;

	grant_e grant;
	logic   last_core1;
	logic   pick_core1;

	// with both routers asking, the one not served last wins.
	assign pick_core1 = req1 && (!req0 || !last_core1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			grant      <= GRANT_NONE;
			last_core1 <= 1'b1;
		end else if (grant == GRANT_NONE) begin
			if (req0 || req1) begin
				grant      <= pick_core1 ? GRANT_CORE1 : GRANT_CORE0;
				last_core1 <= pick_core1;
			end
		end else if (xfer_done) begin
			grant <= GRANT_NONE;
		end
	end

	assign xfer_req   = (grant != GRANT_NONE);
	assign xfer_addr  = (grant == GRANT_CORE1) ? addr1 : addr0;
	assign xfer_wdata = (grant == GRANT_CORE1) ? wdata1 : wdata0;
	assign xfer_wstrb = (grant == GRANT_CORE1) ? wstrb1 : wstrb0;

	// only the owner sees done; read data can go to both.
	assign done0  = xfer_done && (grant == GRANT_CORE0);
	assign done1  = xfer_done && (grant == GRANT_CORE1);
	assign rdata0 = xfer_rdata;
	assign rdata1 = xfer_rdata;

endmodule

`default_nettype wire

/* design/gfx_bus_pkg.sv */
`default_nettype none

package gfx_bus_pkg;

	//////////////////////////////
	// bus widths
	//////////////////////////////

	// every port in the subsystem moves one 32-bit word per transfer.
	typedef logic [31:0] word_t;

	// byte addresses are used on the core ports and on APB alike.
	typedef logic [31:0] addr_t;

	localparam int BYTES_PER_WORD = 4;

	// one strobe per byte lane; a request with no strobe set is a read.
	typedef logic [BYTES_PER_WORD-1:0] strb_t;

	//////////////////////////////
	// address map
	//////////////////////////////

	// byte-offset bits below the word index.
	// the scratchpad word index starts right above them, and a local
	// address has every bit above that index at zero.
	localparam int SUBWORD_BITS = 2;

endpackage

`default_nettype wire

/* design/gfx_sched_pkg.sv */
`default_nettype none

package gfx_sched_pkg;

	// where the router is sending the request it has accepted.
	typedef enum logic [1:0] {
		PATH_IDLE,
		PATH_LOCAL,
		PATH_BUS
	} route_state_e;

	// which router currently owns the shared bus.
	typedef enum logic [1:0] {
		GRANT_NONE,
		GRANT_CORE0,
		GRANT_CORE1
	} grant_e;

	// APB transfer phases.
	typedef enum logic [1:0] {
		APB_IDLE,
		APB_SETUP,
		APB_ACCESS
	} apb_state_e;

endpackage

`default_nettype wire

/* design/gfx_sched_top.sv */
`timescale 1ns/1ps
`default_nettype none

module gfx_sched_top #(
	parameter int SCRATCH_WORDS = 256
) (
	input  wire                     clk,
	input  wire                     rst_n,

	input  wire                     mem0_valid,
	input  wire                     mem1_valid,
	input  wire gfx_bus_pkg::addr_t mem0_addr,
	input  wire gfx_bus_pkg::addr_t mem1_addr,
	input  wire gfx_bus_pkg::word_t mem0_wdata,
	input  wire gfx_bus_pkg::word_t mem1_wdata,
	input  wire gfx_bus_pkg::strb_t mem0_wstrb,
	input  wire gfx_bus_pkg::strb_t mem1_wstrb,
	output logic                    mem0_ready,
	output logic                    mem1_ready,
	output gfx_bus_pkg::word_t      mem0_rdata,
	output gfx_bus_pkg::word_t      mem1_rdata,

	output logic                    psel,
	output logic                    penable,
	output logic                    pwrite,
	output gfx_bus_pkg::addr_t      paddr,
	output gfx_bus_pkg::word_t      pwdata,
	output gfx_bus_pkg::strb_t      pstrb,
	input  wire                     pready,
	input  wire gfx_bus_pkg::word_t prdata
);

	import gfx_bus_pkg::*;

	logic  bus0_req, bus1_req, bus0_done, bus1_done;
	addr_t bus0_addr, bus1_addr;
	word_t bus0_wdata, bus1_wdata, bus0_rdata, bus1_rdata;
	strb_t bus0_wstrb, bus1_wstrb;

	logic  xfer_req, xfer_done;
	addr_t xfer_addr;
	word_t xfer_wdata, xfer_rdata;
	strb_t xfer_wstrb;

	//////////////////////////////
	// one router per core
	//////////////////////////////

	sched_mem_router #(.SCRATCH_WORDS(SCRATCH_WORDS)) i_router0 (
		.clk, .rst_n,
		.mem_valid(mem0_valid), .mem_addr(mem0_addr), .mem_wdata(mem0_wdata),
		.mem_wstrb(mem0_wstrb), .mem_ready(mem0_ready), .mem_rdata(mem0_rdata),
		.bus_req(bus0_req), .bus_addr(bus0_addr), .bus_wdata(bus0_wdata),
		.bus_wstrb(bus0_wstrb), .bus_done(bus0_done), .bus_rdata(bus0_rdata)
	);

	sched_mem_router #(.SCRATCH_WORDS(SCRATCH_WORDS)) i_router1 (
		.clk, .rst_n,
		.mem_valid(mem1_valid), .mem_addr(mem1_addr), .mem_wdata(mem1_wdata),
		.mem_wstrb(mem1_wstrb), .mem_ready(mem1_ready), .mem_rdata(mem1_rdata),
		.bus_req(bus1_req), .bus_addr(bus1_addr), .bus_wdata(bus1_wdata),
		.bus_wstrb(bus1_wstrb), .bus_done(bus1_done), .bus_rdata(bus1_rdata)
	);

	// both routers share the external bus through here.
	bus_arbiter i_arbiter (
		.clk, .rst_n,
		.req0(bus0_req), .req1(bus1_req), .addr0(bus0_addr), .addr1(bus1_addr),
		.wdata0(bus0_wdata), .wdata1(bus1_wdata), .wstrb0(bus0_wstrb), .wstrb1(bus1_wstrb),
		.done0(bus0_done), .done1(bus1_done), .rdata0(bus0_rdata), .rdata1(bus1_rdata),
		.xfer_req, .xfer_addr, .xfer_wdata, .xfer_wstrb, .xfer_done, .xfer_rdata
	);

	apb_master i_apb (
		.clk, .rst_n,
		.xfer_req, .xfer_addr, .xfer_wdata, .xfer_wstrb, .xfer_done, .xfer_rdata,
		.psel, .penable, .pwrite, .paddr, .pwdata, .pstrb, .pready, .prdata
	);

endmodule

`default_nettype wire

/* design/sched_mem_router.sv */
`timescale 1ns/1ps
`default_nettype none

module sched_mem_router #(
	parameter int SCRATCH_WORDS = 256
) (
	input  wire                     clk,
	input  wire                     rst_n,

	input  wire                     mem_valid,
	input  wire gfx_bus_pkg::addr_t mem_addr,
	input  wire gfx_bus_pkg::word_t mem_wdata,
	input  wire gfx_bus_pkg::strb_t mem_wstrb,
	output logic                    mem_ready,
	output gfx_bus_pkg::word_t      mem_rdata,

	output logic                    bus_req,
	output gfx_bus_pkg::addr_t      bus_addr,
	output gfx_bus_pkg::word_t      bus_wdata,
	output gfx_bus_pkg::strb_t      bus_wstrb,
	input  wire                     bus_done,
	input  wire gfx_bus_pkg::word_t bus_rdata
);

	import gfx_bus_pkg::*;
	import gfx_sched_pkg::*;

	localparam int WORD_BITS  = $clog2(SCRATCH_WORDS);
	localparam int LOCAL_BITS = WORD_BITS + SUBWORD_BITS;

	route_state_e         state;
	logic                 accept;
	logic                 is_local;
	logic                 ram_en;
	logic                 ram_ready;
	logic [WORD_BITS-1:0] ram_addr;
	word_t                ram_rdata;

	// a request is taken only from idle, so a held valid is never seen twice.
	assign accept   = mem_valid && (state == PATH_IDLE);
	assign is_local = ~|mem_addr[$bits(addr_t)-1:LOCAL_BITS];
	assign ram_en   = accept && is_local;
	assign ram_addr = mem_addr[LOCAL_BITS-1:SUBWORD_BITS];

	assign ram_ready = (state == PATH_LOCAL);
	assign bus_req   = (state == PATH_BUS);

	// external completion is passed straight through from the arbiter.
	assign mem_ready = ram_ready || (bus_req && bus_done);
	assign mem_rdata = ram_ready ? ram_rdata : bus_rdata;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= PATH_IDLE;
		end else begin
			case (state)
				PATH_IDLE: begin
					if (accept) begin
						state <= is_local ? PATH_LOCAL : PATH_BUS;
					end
				end
				PATH_LOCAL: begin
					state <= PATH_IDLE;
				end
				PATH_BUS: begin
					if (bus_done) begin
						state <= PATH_IDLE;
					end
				end
				default: begin
					state <= PATH_IDLE;
				end
			endcase
		end
	end

	// the bus request is captured once and held until done.
	always_ff @(posedge clk) begin
		if (accept && !is_local) begin
			bus_addr  <= mem_addr;
			bus_wdata <= mem_wdata;
			bus_wstrb <= mem_wstrb;
		end
	end

	//////////////////////////////
	// byte-lane scratchpad
	//////////////////////////////

	for (genvar i = 0; i < BYTES_PER_WORD; i++) begin : g_lane
		logic [7:0] ram [SCRATCH_WORDS];
		logic [7:0] lane_q;

		// read is registered; a write returns the old byte, which nobody uses.
		always_ff @(posedge clk) begin
			if (ram_en) begin
				lane_q <= ram[ram_addr];
				if (mem_wstrb[i]) begin
					ram[ram_addr] <= mem_wdata[8*i +: 8];
				end
			end
		end

		assign ram_rdata[8*i +: 8] = lane_q;
	end

endmodule

`default_nettype wire

/* project.f */
design/gfx_bus_pkg.sv
design/gfx_sched_pkg.sv
design/sched_mem_router.sv
design/bus_arbiter.sv
design/apb_master.sv
design/gfx_sched_top.sv
verification/gfx_sched_props.sv
verification/tb_gfx_sched.sv

/* verification/gfx_sched_props.sv */
`timescale 1ns/1ps
`default_nettype none

module gfx_sched_props #(
	parameter int SCRATCH_WORDS = 256
) (
	input wire                     clk, rst_n,
	input wire                     mem0_valid, mem1_valid, mem0_ready, mem1_ready,
	input wire gfx_bus_pkg::addr_t mem0_addr, mem1_addr, paddr,
	input wire                     psel, penable, pwrite, pready,
	input wire gfx_bus_pkg::word_t pwdata,
	input wire gfx_bus_pkg::strb_t pstrb
);

	import gfx_bus_pkg::*;

	localparam addr_t LOCAL_LIMIT = addr_t'(SCRATCH_WORDS * BYTES_PER_WORD);

	int unsigned fail_count = 0;

	//////////////////////////////
	// core ports
	//////////////////////////////

	// a new local request is answered in the very next cycle.
	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(mem0_valid) && (mem0_addr < LOCAL_LIMIT) |=> mem0_ready) else begin
		fail_count++;
		$error("mem0_ready did not follow a local request by one cycle");
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(mem1_valid) && (mem1_addr < LOCAL_LIMIT) |=> mem1_ready) else begin
		fail_count++;
		$error("mem1_ready did not follow a local request by one cycle");
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		(!mem0_ready || mem0_valid) && (!mem1_ready || mem1_valid)) else begin
		fail_count++;
		$error("a core port saw ready without valid");
	end

	//////////////////////////////
	// APB
	//////////////////////////////

	// every transfer opens with a setup cycle.
	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(psel) |-> !penable) else begin
		fail_count++;
		$error("psel rose together with penable");
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		psel && !penable |=> psel && penable) else begin
		fail_count++;
		$error("setup phase was not followed by access");
	end

	// fields hold from setup until the slave is ready.
	assert property (@(posedge clk) disable iff (!rst_n)
		psel && !(penable && pready) |=> psel && $stable(paddr) && $stable(pwdata)
			&& $stable(pstrb) && $stable(pwrite)) else begin
		fail_count++;
		$error("APB fields changed before pready");
	end

endmodule

bind gfx_sched_top gfx_sched_props #(.SCRATCH_WORDS(SCRATCH_WORDS)) i_props (.*);

`default_nettype wire

/* verification/tb_gfx_sched.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_gfx_sched;

	import gfx_bus_pkg::*;

	localparam int SCRATCH_WORDS = 64;

	logic  clk = 1'b0;
	logic  rst_n = 1'b0;
	logic  mem_valid [2] = '{1'b0, 1'b0};
	addr_t mem_addr [2] = '{'0, '0};
	word_t mem_wdata [2] = '{'0, '0};
	strb_t mem_wstrb [2] = '{'0, '0};
	logic  mem_ready [2];
	word_t mem_rdata [2];
	logic  psel, penable, pwrite;
	addr_t paddr;
	word_t pwdata;
	strb_t pstrb;
	logic  pready = 1'b0;
	word_t prdata = '0;

	addr_t       ext_base;
	word_t       spad_ref [2][8];
	word_t       ext_ref [64];
	word_t       slave_mem [64];
	logic [31:0] lfsr = 32'hbd9;
	logic [1:0]  wait_left;
	bit          grant_order [$];
	bit          first_winner;

	gfx_sched_top #(.SCRATCH_WORDS(SCRATCH_WORDS)) i_dut (
		.clk, .rst_n,
		.mem0_valid(mem_valid[0]), .mem0_addr(mem_addr[0]), .mem0_wdata(mem_wdata[0]),
		.mem0_wstrb(mem_wstrb[0]), .mem0_ready(mem_ready[0]), .mem0_rdata(mem_rdata[0]),
		.mem1_valid(mem_valid[1]), .mem1_addr(mem_addr[1]), .mem1_wdata(mem_wdata[1]),
		.mem1_wstrb(mem_wstrb[1]), .mem1_ready(mem_ready[1]), .mem1_rdata(mem_rdata[1]),
		.psel, .penable, .pwrite, .paddr, .pwdata, .pstrb, .pready, .prdata
	);

	initial begin
		forever begin
			#20 clk = ~clk;
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
	endfunction

	// byte lanes with their strobe set take the new data.
	function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
			input strb_t strb);
		word_t mask;
		mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
		return (old_word & ~mask) | (new_word & mask);
	endfunction

	task automatic fail_with(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	//////////////////////////////
	// APB slave model
	//////////////////////////////

	always @(posedge clk) begin
		if (psel && !penable) begin
			lfsr = lfsr_next(lfsr);
			wait_left[0] = lfsr[0];
			lfsr = lfsr_next(lfsr);
			wait_left[1] = lfsr[0];
			pready <= (wait_left == 2'd0);
			prdata <= slave_mem[paddr[7:2]];
		end else if (psel && penable && !pready) begin
			wait_left = wait_left - 2'd1;
			pready <= (wait_left == 2'd0);
		end else if (psel && penable) begin
			if (pwrite) begin
				slave_mem[paddr[7:2]] = merge_bytes(slave_mem[paddr[7:2]], pwdata, pstrb);
			end
			pready <= 1'b0;
		end
	end

	always @(negedge clk) begin
		if (i_dut.i_props.fail_count != 0) begin
			fail_with("a bound protocol property failed");
		end
	end

	//////////////////////////////
	// core port driver
	//////////////////////////////

	task automatic access(input bit port, input addr_t addr, input word_t wdata,
			input strb_t strb);
		int    cycles;
		bit    is_local;
		word_t expect_data;
		is_local = (addr < ext_base);
		@(posedge clk);
		mem_valid[port] <= 1'b1;
		mem_addr[port]  <= addr;
		mem_wdata[port] <= wdata;
		mem_wstrb[port] <= strb;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (cycles > 64) begin
				fail_with($sformatf("mem%0d_ready never came for address %h", port, addr));
			end
		end while (!mem_ready[port]);
		if (is_local) begin
			expect_data = spad_ref[port][addr[4:2]];
			spad_ref[port][addr[4:2]] = merge_bytes(expect_data, wdata, strb);
		end else begin
			// the APB side carries this very transfer while ready is high.
			expect_data = ext_ref[addr[7:2]];
			ext_ref[addr[7:2]] = merge_bytes(expect_data, wdata, strb);
			grant_order.push_back(port);
			assert (paddr == addr && pstrb == strb && pwrite == (strb != 0))
				else fail_with($sformatf("ERR paddr/pstrb/pwrite %h/%h/%h expected %h/%h/%h",
					paddr, pstrb, pwrite, addr, strb, strb != 0));
			if (strb != 0) begin
				assert (pwdata == wdata)
					else fail_with($sformatf("ERR pwdata %h expected %h", pwdata, wdata));
			end
		end
		if (strb == 0) begin
			assert (mem_rdata[port] == expect_data)
				else fail_with($sformatf("ERR mem%0d_rdata %h expected %h",
					port, mem_rdata[port], expect_data));
		end
		@(posedge clk);
		mem_valid[port] <= 1'b0;
	endtask

	task automatic burst(input bit port, input addr_t base);
		access(port, base, {base[15:0], 16'h5a5a}, 4'hf);
		access(port, base + 32'h4, {16'h3c3c, base[15:0]}, 4'b1100);
		access(port, base, '0, '0);
		access(port, base + 32'h4, '0, '0);
	endtask

	initial begin
		ext_base = addr_t'(i_dut.SCRATCH_WORDS * BYTES_PER_WORD);
		for (int i = 0; i < 64; i++) begin
			slave_mem[i[5:0]] = {4{2'b10, i[5:0]}};
			ext_ref[i[5:0]]   = {4{2'b10, i[5:0]}};
		end
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (!psel && !penable && !mem_ready[0] && !mem_ready[1])
			else fail_with($sformatf(
				"ERR psel/penable/mem0_ready/mem1_ready %h/%h/%h/%h expected 0/0/0/0",
				psel, penable, mem_ready[0], mem_ready[1]));

		// each port keeps its own scratchpad contents at the same address.
		access(1'b0, 32'h8, 32'h1122_3344, 4'hf);
		access(1'b1, 32'h8, 32'haabb_ccdd, 4'hf);
		access(1'b0, 32'h8, 32'h5566_7788, 4'b0101);
		access(1'b1, 32'h8, 32'h99ee_ff00, 4'b1000);
		access(1'b0, 32'h8, '0, '0);
		access(1'b1, 32'h8, '0, '0);
		access(1'b0, 32'h1c, 32'hdead_beef, 4'hf);
		access(1'b0, 32'h1c, '0, '0);

		access(1'b0, ext_base + 32'h10, 32'hcafe_f00d, 4'hf);
		access(1'b0, ext_base + 32'h14, 32'h0bad_cafe, 4'b0011);
		access(1'b0, ext_base + 32'h10, '0, '0);
		access(1'b0, ext_base + 32'h14, '0, '0);
		access(1'b0, ext_base + 32'h20, '0, '0);

		// the port not served last wins the first simultaneous request,
		// and after that the grants take turns between the ports.
		first_winner = !grant_order[grant_order.size() - 1];
		grant_order.delete();
		fork
			burst(1'b0, ext_base);
			burst(1'b1, ext_base + 32'h40);
		join
		assert (grant_order.size() == 8)
			else fail_with("not every contended transfer reached the APB bus");
		assert (grant_order[0] == first_winner)
			else fail_with("the first contended transfer went to the port served last");
		for (int k = 1; k < grant_order.size(); k++) begin
			assert (grant_order[k] != grant_order[k - 1])
				else fail_with("two contended transfers in a row went to the same port");
		end

		@(posedge clk);
		if (i_dut.i_props.fail_count == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			fail_with("a bound protocol property failed");
		end
	end

endmodule

`default_nettype wire
